// File: vlog.f
+incdir+include
hdl/tdmr_pkg.sv
hdl/tdmr_stream_if.sv
hdl/tdmr_start.sv
hdl/tdmr_compute.sv
hdl/tdmr_end.sv
hdl/tdmr_top.sv
verification/tdmr_chk.sv
verification/tdmr_tb.sv

// File: Makefile
TOP := tdmr_tb

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

# Verdict comes from the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: verification/tdmr_tb.sv
`default_nettype none

`include "tdmr_config.svh"

module tdmr_tb;
    import tdmr_pkg::*;

    // 55 elements in all
    // Each takes well under 70 cycles even with back-pressure
    localparam int unsigned MaxCycles = 4000;
    localparam data_t       FaultMask = 16'h0101;

    logic  clk_i = 1'b0;
    logic  rst_ni;
    logic  enable_i;
    data_t data_i;
    logic  valid_i;
    logic  ready_o;
    data_t data_o;
    logic  valid_o;
    logic  ready_i;
    logic  faulty_o;
    logic  fault_arm_i;
    data_t fault_mask_i;

    // Reference model holds one entry per accepted input in order
    data_t       exp_data_q [$];
    logic        exp_fault_q [$];
    int unsigned errors = 0;
    int unsigned outputs = 0;
    int unsigned cycles = 0;
    logic [31:0] data_state = 32'd24;
    logic [31:0] bp_state = 32'd24;
    logic        bp_en = 1'b0;

    tdmr_top i_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .enable_i     (enable_i),
        .data_i       (data_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .data_o       (data_o),
        .valid_o      (valid_o),
        .ready_i      (ready_i),
        .faulty_o     (faulty_o),
        .fault_arm_i  (fault_arm_i),
        .fault_mask_i (fault_mask_i)
    );

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic data_t next_data();
        data_state = lcg_next(data_state);
        return data_state[31:16];
    endfunction

    // Times three plus the key modulo 2^16
    function automatic data_t expected_result(input data_t d);
        return data_t'(32'(d) * 32'd3 + 32'(`TDMR_KEY));
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // One input handshake that may arm the fault on the first copy
    task automatic send_element(input data_t d, input logic arm);
        @(posedge clk_i);
        valid_i     <= 1'b1;
        data_i      <= d;
        fault_arm_i <= arm;
        @(negedge clk_i);
        while (!ready_o) begin
            @(posedge clk_i);
            fault_arm_i <= 1'b0;
            @(negedge clk_i);
        end
        exp_data_q.push_back(expected_result(d));
        exp_fault_q.push_back(arm);
        @(posedge clk_i);
        valid_i     <= 1'b0;
        fault_arm_i <= 1'b0;
    endtask

    // Drain and wait a quiet spell so extra results show up in the count
    task automatic expect_results(input int unsigned first, input int unsigned count,
                                  input string name);
        while (exp_data_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (12) @(negedge clk_i);
        check_value(outputs - first, count, name);
    endtask

    //////////////////////////////
    // Directed tests

    task automatic reset_state();
        repeat (8) begin
            @(negedge clk_i);
            check_value(valid_o, 1'b0, "valid_o in reset");
            check_value(faulty_o, 1'b0, "faulty_o in reset");
        end
        @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value(valid_o, 1'b0, "valid_o after reset");
        check_value(faulty_o, 1'b0, "faulty_o after reset");
    endtask

    task automatic redundant_stream();
        int unsigned first;
        first = outputs;
        for (int i = 0; i < 20; i++) begin
            send_element(next_data(), 1'b0);
        end
        expect_results(first, 20, "redundant result count");
    endtask

    task automatic backpressure_stream();
        int unsigned first;
        first = outputs;
        @(negedge clk_i);
        bp_en = 1'b1;
        for (int i = 0; i < 20; i++) begin
            send_element(next_data(), 1'b0);
        end
        while (exp_data_q.size() != 0) begin
            @(negedge clk_i);
        end
        bp_en = 1'b0;
        expect_results(first, 20, "back-pressure result count");
    endtask

    // Pipeline is empty here so the mask lands on the first copy
    task automatic fault_detection();
        int unsigned first;
        first = outputs;
        @(posedge clk_i);
        fault_mask_i <= FaultMask;
        send_element(next_data(), 1'b1);
        for (int i = 0; i < 4; i++) begin
            send_element(next_data(), 1'b0);
        end
        expect_results(first, 5, "fault test result count");
    endtask

    task automatic bypass_stream();
        int unsigned first;
        first = outputs;
        @(posedge clk_i);
        enable_i <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            send_element(next_data(), 1'b0);
        end
        expect_results(first, 10, "bypass result count");
    endtask

    //////////////////////////////
    // Ready toggling, monitor and timeout

    always @(posedge clk_i) begin
        if (bp_en) begin
            bp_state = lcg_next(bp_state);
            ready_i <= bp_state[29];
        end else begin
            ready_i <= 1'b1;
        end
    end

    // Every output transfer counts, expected or not
    always @(negedge clk_i) begin : monitor
        data_t exp_d;
        logic  exp_f;
        if (rst_ni && valid_o && ready_i) begin
            outputs++;
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Unexpected result %0h at %0t with nothing outstanding",
                         data_o, $time);
            end else begin
                exp_d = exp_data_q.pop_front();
                exp_f = exp_fault_q.pop_front();
                check_value(faulty_o, exp_f, "faulty_o");
                if (exp_f) begin
                    // Either copy may be the corrupted one
                    check_value(32'(data_o == exp_d || data_o == (exp_d ^ FaultMask)), 1,
                                "faulty data_o");
                end else begin
                    check_value(data_o, exp_d, "data_o");
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Run timed out after %0d cycles with %0d results outstanding",
                     MaxCycles, exp_data_q.size());
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst_ni       = 1'b0;
        enable_i     = 1'b1;
        data_i       = '0;
        valid_i      = 1'b0;
        ready_i      = 1'b1;
        fault_arm_i  = 1'b0;
        fault_mask_i = '0;
        reset_state();
        redundant_stream();
        backpressure_stream();
        fault_detection();
        bypass_stream();
        $display("Checked %0d results, %0d errors, %0d assertion failures",
                 outputs, errors, i_dut.i_chk.fail_cnt);
        if (errors == 0 && i_dut.i_chk.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tdmr_chk.sv
`default_nettype none

module tdmr_chk (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            enable_i,
    input logic            valid_i,
    input logic            ready_o,
    input tdmr_pkg::data_t data_o,
    input logic            valid_o,
    input logic            ready_i,
    input logic            faulty_o
);

    // Failed assertion count
    int unsigned fail_cnt = 0;

    // Held result keeps valid and data
    hold_result_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(data_o))
    else begin
        fail_cnt++;
        $error("data_o changed while the result waited for ready_i");
    end

    faulty_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        faulty_o |-> valid_o)
    else begin
        fail_cnt++;
        $error("faulty_o high without valid_o");
    end

    // Cycle after an accepted input is a first copy
    first_copy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        enable_i && valid_i && ready_o |=> !enable_i || !ready_o)
    else begin
        fail_cnt++;
        $error("ready_o high during a first copy");
    end

endmodule

bind tdmr_top tdmr_chk i_chk (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (enable_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .data_o   (data_o),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .faulty_o (faulty_o)
);

`default_nettype wire

// File: hdl/tdmr_top.sv
`default_nettype none

module tdmr_top (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            enable_i,
    input  tdmr_pkg::data_t data_i,
    input  logic            valid_i,
    output logic            ready_o,
    output tdmr_pkg::data_t data_o,
    output logic            valid_o,
    input  logic            ready_i,
    output logic            faulty_o,
    input  logic            fault_arm_i,
    input  tdmr_pkg::data_t fault_mask_i
);
    import tdmr_pkg::*;

    // Direct ID link from start to end
    id_t next_id;

    // Start to datapath
    tdmr_stream_if s_fwd ();
    // Datapath to end
    tdmr_stream_if s_res ();

    tdmr_start i_start (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .enable_i  (enable_i),
        .data_i    (data_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .fwd       (s_fwd),
        .next_id_o (next_id)
    );

    tdmr_compute i_compute (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fault_arm_i  (fault_arm_i),
        .fault_mask_i (fault_mask_i),
        .in           (s_fwd),
        .out          (s_res)
    );

    tdmr_end i_end (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .enable_i  (enable_i),
        .next_id_i (next_id),
        .res       (s_res),
        .data_o    (data_o),
        .valid_o   (valid_o),
        .ready_i   (ready_i),
        .faulty_o  (faulty_o)
    );

endmodule

`default_nettype wire

// File: hdl/tdmr_end.sv
`default_nettype none

`include "voters.svh"

module tdmr_end (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            enable_i,
    input  tdmr_pkg::id_t   next_id_i,
    tdmr_stream_if.snk      res,
    output tdmr_pkg::data_t data_o,
    output logic            valid_o,
    input  logic            ready_i,
    output logic            faulty_o
);
    import tdmr_pkg::*;

    typedef enum logic [1:0] {BASE, WAIT_FOR_READY, WAIT_FOR_VALID} state_t;

    localparam int unsigned SeqW  = $bits(seq_t);
    // One seen flag per sequence value
    localparam int unsigned SeenN = 2 ** SeqW;

    data_t            data_q;
    id_t              id_q;
    seq_t             id_seq;
    seq_t             next_seq;
    logic             accept;
    logic             id_fault;
    logic [2:0]       data_same_in;
    logic [2:0]       id_same_in;
    logic [2:0]       id_same_v;
    logic [2:0]       id_same_d;
    logic [2:0]       id_same_q;
    logic [2:0]       new_element;
    data_t            data_ov [3];
    state_t           state_v [3];
    state_t           state_d [3];
    state_t           state_q [3];
    logic [2:0]       valid_int;
    logic [2:0]       ready_ov;
    logic [2:0]       valid_ov;
    logic [2:0]       faulty_ov;
    logic [SeenN-1:0] seen_v [3];
    logic [SeenN-1:0] seen_d [3];
    logic [SeenN-1:0] seen_q [3];

    //////////////////////////////
    // Storage of the last copy

    assign accept   = res.valid && res.ready && enable_i;
    // Stored ID must have even parity
    assign id_fault = ^id_q;
    assign id_seq   = id_q[SeqW-1:0];
    assign next_seq = next_id_i[SeqW-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // Odd parity so nothing stale is forwarded
            id_q <= id_t'(1);
        end else if (accept) begin
            id_q <= res.id;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q <= res.data;
        end
    end

    for (genvar r = 0; r < 3; r++) begin : g_rep
        // Incoming copy against the stored one
        always_comb begin
            data_same_in[r] = (res.data == data_q);
            id_same_in[r]   = (res.id == id_q);
            id_same_v[r]    = accept ? id_same_in[r] : id_same_q[r];
            // Stored copy opened a new ID, incoming one closes the pair
            new_element[r]  = !id_same_q[r];
            data_ov[r]      = enable_i ? data_q : res.data;
        end

        // Handshake FSM next state
        always_comb begin
            state_v[r] = state_q[r];
            case (state_q[r])
                BASE: begin
                    if (res.valid && new_element[r]) begin
                        state_v[r] = ready_i ? WAIT_FOR_VALID : WAIT_FOR_READY;
                    end
                end
                // Result held until downstream takes it
                WAIT_FOR_READY: begin
                    if (ready_i) begin
                        state_v[r] = BASE;
                    end
                end
                // one shift back into BASE
                default: begin
                    if (res.valid) begin
                        state_v[r] = BASE;
                    end
                end
            endcase
        end

        // Handshake outputs, dedup and fault flag
        always_comb begin
            if (enable_i) begin
                case (state_q[r])
                    BASE: begin
                        valid_int[r] = res.valid && new_element[r];
                        ready_ov[r]  = ready_i || !new_element[r];
                    end
                    WAIT_FOR_READY: begin
                        valid_int[r] = res.valid;
                        ready_ov[r]  = ready_i;
                    end
                    default: begin
                        valid_int[r] = 1'b0;
                        ready_ov[r]  = !res.valid;
                    end
                endcase
                valid_ov[r]  = valid_int[r] && !id_fault && !seen_q[r][id_seq];
                // Same ID but different data
                faulty_ov[r] = valid_ov[r] && id_same_in[r] && !data_same_in[r];
            end else begin
                valid_int[r] = res.valid;
                ready_ov[r]  = ready_i;
                valid_ov[r]  = res.valid;
                faulty_ov[r] = 1'b0;
            end
        end

        // Recently-seen table, the set wins over the clear
        always_comb begin
            seen_v[r]           = seen_q[r];
            seen_v[r][next_seq] = 1'b0;
            if (enable_i && valid_int[r] && ready_i && !id_fault) begin
                seen_v[r][id_seq] = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Voting and state storage

    always_comb begin
        `VOTE3to3ENUM(state_t, state_v, state_d);
        `VOTE3to3(id_same_v, id_same_d);
        `VOTE3to3(seen_v, seen_d);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= '{default: WAIT_FOR_VALID};
            id_same_q <= '1;
            seen_q    <= '{default: '1};
        end else begin
            state_q   <= state_d;
            id_same_q <= id_same_d;
            seen_q    <= seen_d;
        end
    end

    always_comb begin
        `VOTE3to1(ready_ov, res.ready);
        `VOTE3to1(valid_ov, valid_o);
        `VOTE3to1(faulty_ov, faulty_o);
        `VOTE3to1(data_ov, data_o);
    end

endmodule

`default_nettype wire

// File: hdl/tdmr_compute.sv
`default_nettype none

`include "tdmr_config.svh"

module tdmr_compute (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            fault_arm_i,
    input  tdmr_pkg::data_t fault_mask_i,
    tdmr_stream_if.snk      in,
    tdmr_stream_if.src      out
);
    import tdmr_pkg::*;

    logic  s1_valid_q;
    logic  s2_valid_q;
    data_t s1_data_q;
    data_t s2_data_q;
    id_t   s1_id_q;
    id_t   s2_id_q;
    logic  s1_load;
    logic  s2_load;
    logic  s2_free;
    logic  fault_armed_q;
    data_t fault_mask_q;
    data_t fault_xor;

    //////////////////////////////
    // Pipeline flow control

    // Stage two empties or hands over this cycle
    assign s2_free  = !s2_valid_q || out.ready;
    assign s2_load  = s1_valid_q && s2_free;
    // Upstream stalls only with both stages full
    assign in.ready = !s1_valid_q || s2_free;
    assign s1_load  = in.valid && in.ready;

    // Mask hits the next element entering stage two
    assign fault_xor = fault_armed_q ? fault_mask_q : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q    <= 1'b0;
            s2_valid_q    <= 1'b0;
            fault_armed_q <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid_q <= 1'b1;
            end else if (s2_load) begin
                s1_valid_q <= 1'b0;
            end
            if (s2_load) begin
                s2_valid_q <= 1'b1;
            end else if (out.ready) begin
                s2_valid_q <= 1'b0;
            end
            // One shot, a new arm pulse takes priority
            if (s2_load) begin
                fault_armed_q <= 1'b0;
            end
            if (fault_arm_i) begin
                fault_armed_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Arithmetic stages

    always_ff @(posedge clk_i) begin
        // Stage one, times three modulo 2^16
        if (s1_load) begin
            s1_data_q <= data_t'(in.data * 3);
            s1_id_q   <= in.id;
        end
        // Stage two, add the key
        if (s2_load) begin
            s2_data_q <= (s1_data_q + data_t'(`TDMR_KEY)) ^ fault_xor;
            s2_id_q   <= s1_id_q;
        end
        if (fault_arm_i) begin
            fault_mask_q <= fault_mask_i;
        end
    end

    assign out.valid = s2_valid_q;
    assign out.data  = s2_data_q;
    assign out.id    = s2_id_q;

endmodule

`default_nettype wire

// File: hdl/tdmr_start.sv
`default_nettype none

`include "voters.svh"

module tdmr_start (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            enable_i,
    input  tdmr_pkg::data_t data_i,
    input  logic            valid_i,
    output logic            ready_o,
    tdmr_stream_if.src      fwd,
    output tdmr_pkg::id_t   next_id_o
);
    import tdmr_pkg::*;

    typedef enum logic {FIRST_COPY, SECOND_COPY} copy_t;

    localparam int unsigned SeqW = $bits(seq_t);

    // Triplicated copy counter and ID register
    copy_t      copy_v [3];
    copy_t      copy_d [3];
    copy_t      copy_q [3];
    id_t        id_v [3];
    id_t        id_d [3];
    id_t        id_q [3];
    logic [2:0] ready_ov;
    logic       send;
    id_t        id_cur;

    // One copy leaves toward the datapath
    assign send = enable_i && valid_i && fwd.ready;

    for (genvar r = 0; r < 3; r++) begin : g_rep
        always_comb begin
            seq_t seq_next;
            seq_next  = id_q[r][SeqW-1:0] + seq_t'(1);
            copy_v[r] = copy_q[r];
            id_v[r]   = id_q[r];
            if (send) begin
                if (copy_q[r] == FIRST_COPY) begin
                    copy_v[r] = SECOND_COPY;
                end else begin
                    // Pair done, step the sequence and rebuild even parity
                    copy_v[r] = FIRST_COPY;
                    id_v[r]   = {^seq_next, seq_next};
                end
            end
            // Source is held while the first copy goes out
            if (enable_i) begin
                ready_ov[r] = (copy_q[r] == SECOND_COPY) && fwd.ready;
            end else begin
                ready_ov[r] = fwd.ready;
            end
        end
    end

    always_comb begin
        `VOTE3to3ENUM(copy_t, copy_v, copy_d);
        `VOTE3to3(id_v, id_d);
        `VOTE3to1(id_q, id_cur);
        `VOTE3to1(ready_ov, ready_o);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            copy_q <= '{default: FIRST_COPY};
            id_q   <= '{default: '0};
        end else begin
            copy_q <= copy_d;
            id_q   <= id_d;
        end
    end

    // Both copies carry the same data and ID
    assign fwd.valid = valid_i;
    assign fwd.data  = data_i;
    assign fwd.id    = id_cur;

    // ID the next outgoing copy uses
    // end block clears its seen flag
    assign next_id_o = id_cur;

endmodule

`default_nettype wire

// File: hdl/tdmr_stream_if.sv
`default_nettype none

interface tdmr_stream_if;
    import tdmr_pkg::*;

    // Plain valid/ready stream with an ID beside the data
    logic  valid;
    logic  ready;
    data_t data;
    id_t   id;

    // Producer side
    modport src (output valid, output data, output id, input ready);

    // Consumer side
    modport snk (input valid, input data, input id, output ready);

endinterface

`default_nettype wire

// File: hdl/tdmr_pkg.sv
`default_nettype none

`include "tdmr_config.svh"

package tdmr_pkg;

    // Payload word carried through the datapath
    typedef logic [`TDMR_DATA_W-1:0] data_t;

    // Element ID with the parity bit as MSB
    typedef logic [`TDMR_ID_W-1:0] id_t;

    // Sequence part of an ID
    // Also indexes the recently-seen table
    typedef logic [`TDMR_ID_W-2:0] seq_t;

endpackage

`default_nettype wire

// File: include/tdmr_config.svh
`ifndef TDMR_CONFIG_SVH
`define TDMR_CONFIG_SVH

// Width of one payload word
`define TDMR_DATA_W 16

// One sequence bit plus one parity bit
// The whole ID vector has even parity
`define TDMR_ID_W 2

// Constant added in the second datapath stage
`define TDMR_KEY 16'h5A3C

`endif

// File: include/voters.svh
`ifndef TDMR_VOTERS_SVH
`define TDMR_VOTERS_SVH

// Bitwise two-out-of-three majority
`define TDMR_MAJ(a, b, c) (((a) & (b)) | ((a) & (c)) | ((b) & (c)))

// Three replicas voted down to one signal
`define VOTE3to1(in_sig, out_sig) \
    out_sig = `TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2])

// Three replicas voted back into three replicas
`define VOTE3to3(in_sig, out_sig) \
    out_sig[0] = `TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2]); \
    out_sig[1] = `TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2]); \
    out_sig[2] = `TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2])

// Same for FSM states, cast back to the enum type
`define VOTE3to3ENUM(etype, in_sig, out_sig) \
    out_sig[0] = etype'(`TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2])); \
    out_sig[1] = etype'(`TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2])); \
    out_sig[2] = etype'(`TDMR_MAJ(in_sig[0], in_sig[1], in_sig[2]))

`endif
